/* design/gb_access_ctrl.sv */
`timescale 1ns/1ns

module gb_access_ctrl (
	gb_mem_sel_if.ctrl                  cpu_sel,
	gb_mem_sel_if.ctrl                  dma_sel,
	input  logic                        dma_active,
	input  logic                        ppu_need_vram,
	input  logic                        ppu_need_oam,
	output gb_bus_pkg::vram_owner_e     vram_owner,
	output gb_bus_pkg::oam_owner_e      oam_owner,
	output gb_bus_pkg::ext_owner_e      ext_owner,
	output gb_bus_pkg::cpu_src_e        cpu_src,
	output gb_bus_pkg::cpu_src_e        dma_src
);

	logic cpu_ext;
	logic dma_ext;

	assign cpu_ext = cpu_sel.rom || cpu_sel.xram || cpu_sel.wram;
	assign dma_ext = dma_sel.rom || dma_sel.xram || dma_sel.wram;

	always_comb begin
		if (ppu_need_vram)
			vram_owner = gb_bus_pkg::VRAM_PPU;
		else if (dma_active && dma_sel.vram)
			vram_owner = gb_bus_pkg::VRAM_DMA;
		else if (cpu_sel.vram)
			vram_owner = gb_bus_pkg::VRAM_CPU;
		else
			vram_owner = gb_bus_pkg::VRAM_NONE;

		// A running OAM DMA always writes OAM whatever its source address
		if (ppu_need_oam)
			oam_owner = gb_bus_pkg::OAM_PPU;
		else if (dma_active)
			oam_owner = gb_bus_pkg::OAM_DMA;
		else if (cpu_sel.oam)
			oam_owner = gb_bus_pkg::OAM_CPU;
		else
			oam_owner = gb_bus_pkg::OAM_NONE;

		ext_owner = (dma_active && dma_ext) ? gb_bus_pkg::EXT_DMA : gb_bus_pkg::EXT_CPU;

		if (cpu_sel.io)
			cpu_src = gb_bus_pkg::SRC_IO;
		else if (cpu_sel.vram && vram_owner == gb_bus_pkg::VRAM_CPU)
			cpu_src = gb_bus_pkg::SRC_VRAM;
		else if (cpu_sel.oam && oam_owner == gb_bus_pkg::OAM_CPU)
			cpu_src = gb_bus_pkg::SRC_OAM;
		else if (cpu_ext && ext_owner == gb_bus_pkg::EXT_CPU)
			cpu_src = gb_bus_pkg::SRC_EXT;
		else
			cpu_src = gb_bus_pkg::SRC_OPEN;

		if (dma_sel.vram && !ppu_need_vram)
			dma_src = gb_bus_pkg::SRC_VRAM;
		else if (ext_owner == gb_bus_pkg::EXT_DMA)
			dma_src = gb_bus_pkg::SRC_EXT;
		else
			dma_src = gb_bus_pkg::SRC_OPEN;

		// The DMA engine sees VRAM data only while it owns VRAM and so never while the PPU fetches
		assert (!(dma_src == gb_bus_pkg::SRC_VRAM && vram_owner != gb_bus_pkg::VRAM_DMA))
			else $error("gb_access_ctrl: DMA reads VRAM that it does not own");
	end

endmodule

/* design/gb_bus_fabric.sv */
`timescale 1ns/1ns

module gb_bus_fabric (
	input  logic                     gbclk,
	input  logic                     rst_n,
	input  logic                     power_on,

	input  gb_bus_pkg::gb_adr_t      cpu_adr,
	input  logic                     cpu_rd,
	input  logic                     cpu_wr,
	input  gb_bus_pkg::gb_data_t     cpu_dout,
	output gb_bus_pkg::gb_data_t     cpu_din,

	input  logic                     dma_active,
	input  gb_bus_pkg::gb_adr_t      dma_adr_rd,
	input  gb_bus_pkg::gb_oam_adr_t  dma_adr_wr,
	input  logic                     dma_rd,
	input  logic                     dma_wr,
	input  gb_bus_pkg::gb_data_t     dma_dout,
	output gb_bus_pkg::gb_data_t     dma_din,

	input  logic                     ppu_need_vram,
	input  logic                     ppu_need_oam,
	input  gb_bus_pkg::gb_adr_t      ppu_adr,
	input  logic                     ppu_rd,

	input  gb_bus_pkg::gb_data_t     vram_dout,
	output gb_bus_pkg::gb_vram_adr_t vram_adr,
	output logic                     vram_rd,
	output logic                     vram_wr,

	input  gb_bus_pkg::gb_data_t     oam_dout,
	output gb_bus_pkg::gb_oam_adr_t  oam_adr,
	output logic                     oam_rd,
	output logic                     oam_wr,
	output gb_bus_pkg::gb_data_t     oam_din,

	input  gb_bus_pkg::gb_data_t     ext_data_in,
	output gb_bus_pkg::gb_adr_t      ext_adr,
	output logic                     ext_rd,
	output logic                     ext_wr,
	output logic                     ext_data_oe,
	output logic                     cs_rom,
	output logic                     cs_xram,
	output logic                     cs_wram,

	input  gb_bus_pkg::gb_data_t     io_dout,
	output logic                     reset_gb
);

	gb_bus_pkg::vram_owner_e vram_owner;
	gb_bus_pkg::oam_owner_e  oam_owner;
	gb_bus_pkg::ext_owner_e  ext_owner;
	gb_bus_pkg::cpu_src_e    cpu_src;
	gb_bus_pkg::cpu_src_e    dma_src;
	logic                    reset_done;

	gb_mem_sel_if cpu_sel ();
	gb_mem_sel_if dma_sel ();

	gb_mem_decode u_cpu_decode (
		.adr    (cpu_adr),
		.enable (1'b1),
		.sel    (cpu_sel)
	);

	// An idle DMA engine selects nothing
	gb_mem_decode u_dma_decode (
		.adr    (dma_adr_rd),
		.enable (dma_active),
		.sel    (dma_sel)
	);

	gb_access_ctrl u_access_ctrl (
		.cpu_sel       (cpu_sel),
		.dma_sel       (dma_sel),
		.dma_active    (dma_active),
		.ppu_need_vram (ppu_need_vram),
		.ppu_need_oam  (ppu_need_oam),
		.vram_owner    (vram_owner),
		.oam_owner     (oam_owner),
		.ext_owner     (ext_owner),
		.cpu_src       (cpu_src),
		.dma_src       (dma_src)
	);

	gb_bus_mux u_bus_mux (
		.vram_owner  (vram_owner),
		.oam_owner   (oam_owner),
		.cpu_src     (cpu_src),
		.dma_src     (dma_src),
		.cpu_adr     (cpu_adr),
		.cpu_rd      (cpu_rd),
		.cpu_wr      (cpu_wr),
		.cpu_dout    (cpu_dout),
		.dma_adr_rd  (dma_adr_rd),
		.dma_adr_wr  (dma_adr_wr),
		.dma_rd      (dma_rd),
		.dma_wr      (dma_wr),
		.dma_dout    (dma_dout),
		.ppu_adr     (ppu_adr),
		.ppu_rd      (ppu_rd),
		.vram_dout   (vram_dout),
		.oam_dout    (oam_dout),
		.ext_data_in (ext_data_in),
		.io_dout     (io_dout),
		.vram_adr    (vram_adr),
		.vram_rd     (vram_rd),
		.vram_wr     (vram_wr),
		.oam_adr     (oam_adr),
		.oam_rd      (oam_rd),
		.oam_wr      (oam_wr),
		.oam_din     (oam_din),
		.cpu_din     (cpu_din),
		.dma_din     (dma_din)
	);

	gb_ext_port u_ext_port (
		.gbclk       (gbclk),
		.rst_n       (rst_n),
		.reset_done  (reset_done),
		.ext_owner   (ext_owner),
		.cpu_adr     (cpu_adr),
		.dma_adr_rd  (dma_adr_rd),
		.cpu_rd      (cpu_rd),
		.cpu_wr      (cpu_wr),
		.dma_rd      (dma_rd),
		.cpu_sel     (cpu_sel),
		.dma_sel     (dma_sel),
		.ext_adr     (ext_adr),
		.ext_rd      (ext_rd),
		.ext_wr      (ext_wr),
		.ext_data_oe (ext_data_oe),
		.cs_rom      (cs_rom),
		.cs_xram     (cs_xram),
		.cs_wram     (cs_wram)
	);

	gb_reset_seq u_reset_seq (
		.gbclk      (gbclk),
		.rst_n      (rst_n),
		.power_on   (power_on),
		.reset_done (reset_done),
		.reset_gb   (reset_gb)
	);

endmodule

/* design/gb_bus_mux.sv */
`timescale 1ns/1ns
`include "gb_config.svh"

module gb_bus_mux (
	input  gb_bus_pkg::vram_owner_e  vram_owner,
	input  gb_bus_pkg::oam_owner_e   oam_owner,
	input  gb_bus_pkg::cpu_src_e     cpu_src,
	input  gb_bus_pkg::cpu_src_e     dma_src,
	input  gb_bus_pkg::gb_adr_t      cpu_adr,
	input  logic                     cpu_rd,
	input  logic                     cpu_wr,
	input  gb_bus_pkg::gb_data_t     cpu_dout,
	input  gb_bus_pkg::gb_adr_t      dma_adr_rd,
	input  gb_bus_pkg::gb_oam_adr_t  dma_adr_wr,
	input  logic                     dma_rd,
	input  logic                     dma_wr,
	input  gb_bus_pkg::gb_data_t     dma_dout,
	input  gb_bus_pkg::gb_adr_t      ppu_adr,
	input  logic                     ppu_rd,
	input  gb_bus_pkg::gb_data_t     vram_dout,
	input  gb_bus_pkg::gb_data_t     oam_dout,
	input  gb_bus_pkg::gb_data_t     ext_data_in,
	input  gb_bus_pkg::gb_data_t     io_dout,
	output gb_bus_pkg::gb_vram_adr_t vram_adr,
	output logic                     vram_rd,
	output logic                     vram_wr,
	output gb_bus_pkg::gb_oam_adr_t  oam_adr,
	output logic                     oam_rd,
	output logic                     oam_wr,
	output gb_bus_pkg::gb_data_t     oam_din,
	output gb_bus_pkg::gb_data_t     cpu_din,
	output gb_bus_pkg::gb_data_t     dma_din
);

	// Only the CPU ever writes VRAM
	always_comb begin
		vram_adr = '0;
		vram_rd  = 1'b0;
		vram_wr  = 1'b0;
		case (vram_owner)
			gb_bus_pkg::VRAM_PPU: begin
				vram_adr = gb_bus_pkg::gb_vram_adr_t'(ppu_adr);
				vram_rd  = ppu_rd;
			end
			gb_bus_pkg::VRAM_DMA: begin
				vram_adr = gb_bus_pkg::gb_vram_adr_t'(dma_adr_rd);
				vram_rd  = dma_rd;
			end
			gb_bus_pkg::VRAM_CPU: begin
				vram_adr = gb_bus_pkg::gb_vram_adr_t'(cpu_adr);
				vram_rd  = cpu_rd;
				vram_wr  = cpu_wr;
			end
			default: ;
		endcase
	end

	always_comb begin
		oam_adr = '0;
		oam_rd  = 1'b0;
		oam_wr  = 1'b0;
		oam_din = cpu_dout;
		case (oam_owner)
			gb_bus_pkg::OAM_PPU: begin
				oam_adr = gb_bus_pkg::gb_oam_adr_t'(ppu_adr);
				oam_rd  = ppu_rd;
			end
			gb_bus_pkg::OAM_DMA: begin
				oam_adr = dma_adr_wr;
				oam_wr  = dma_wr;
				oam_din = dma_dout;
			end
			gb_bus_pkg::OAM_CPU: begin
				oam_adr = gb_bus_pkg::gb_oam_adr_t'(cpu_adr);
				oam_rd  = cpu_rd;
				oam_wr  = cpu_wr;
			end
			default: ;
		endcase
	end

	always_comb begin
		case (cpu_src)
			gb_bus_pkg::SRC_VRAM: cpu_din = vram_dout;
			gb_bus_pkg::SRC_OAM:  cpu_din = oam_dout;
			gb_bus_pkg::SRC_EXT:  cpu_din = ext_data_in;
			gb_bus_pkg::SRC_IO:   cpu_din = io_dout;
			default:              cpu_din = `GB_OPEN_BUS;
		endcase

		case (dma_src)
			gb_bus_pkg::SRC_VRAM: dma_din = vram_dout;
			gb_bus_pkg::SRC_EXT:  dma_din = ext_data_in;
			default:              dma_din = `GB_OPEN_BUS;
		endcase
	end

endmodule

/* design/gb_bus_pkg.sv */
`include "gb_config.svh"

package gb_bus_pkg;

	typedef logic [`GB_ADR_W-1:0]  gb_adr_t;
	typedef logic [`GB_DATA_W-1:0] gb_data_t;
	typedef logic [12:0]           gb_vram_adr_t;
	typedef logic [7:0]            gb_oam_adr_t;

	// Who drives VRAM this cycle
	typedef enum logic [1:0] {
		VRAM_NONE,
		VRAM_PPU,
		VRAM_DMA,
		VRAM_CPU
	} vram_owner_e;

	typedef enum logic [1:0] {
		OAM_NONE,
		OAM_PPU,
		OAM_DMA,
		OAM_CPU
	} oam_owner_e;

	// The cartridge and work RAM bus always has a master
	typedef enum logic {
		EXT_CPU,
		EXT_DMA
	} ext_owner_e;

	// Read data source shared by the CPU and the DMA engine
	typedef enum logic [2:0] {
		SRC_OPEN,
		SRC_VRAM,
		SRC_OAM,
		SRC_EXT,
		SRC_IO
	} cpu_src_e;

	typedef enum logic [1:0] {
		RST_COUNT,
		RST_RUN,
		RST_OFF
	} reset_state_e;

endpackage

/* design/gb_config.svh */
`ifndef GB_CONFIG_SVH
`define GB_CONFIG_SVH

// Bus widths
`define GB_ADR_W        16
`define GB_DATA_W       8

// Cycles the console is held in reset after power or system reset
`define GB_RESET_TICKS  15

// Each region of the memory map runs up to the next base
`define GB_VRAM_BASE    16'h8000
`define GB_XRAM_BASE    16'hA000
`define GB_WRAM_BASE    16'hC000
`define GB_ECHO_END     16'hFE00
`define GB_OAM_BASE     16'hFE00
`define GB_OAM_END      16'hFEA0
`define GB_IO_BASE      16'hFF00

// Pulled-up data bus when nothing drives it
`define GB_OPEN_BUS     8'hFF

`endif

/* design/gb_ext_port.sv */
`timescale 1ns/1ns

module gb_ext_port (
	input  logic                   gbclk,
	input  logic                   rst_n,
	input  logic                   reset_done,
	input  gb_bus_pkg::ext_owner_e ext_owner,
	input  gb_bus_pkg::gb_adr_t    cpu_adr,
	input  gb_bus_pkg::gb_adr_t    dma_adr_rd,
	input  logic                   cpu_rd,
	input  logic                   cpu_wr,
	input  logic                   dma_rd,
	gb_mem_sel_if.ctrl             cpu_sel,
	gb_mem_sel_if.ctrl             dma_sel,
	output gb_bus_pkg::gb_adr_t    ext_adr,
	output logic                   ext_rd,
	output logic                   ext_wr,
	output logic                   ext_data_oe,
	output logic                   cs_rom,
	output logic                   cs_xram,
	output logic                   cs_wram
);

	logic cpu_ext;
	logic rd_next;
	logic wr_next;

	assign cpu_ext = cpu_sel.rom || cpu_sel.xram || cpu_sel.wram;

	// The DMA engine only reads from the external bus
	always_comb begin
		if (ext_owner == gb_bus_pkg::EXT_DMA) begin
			rd_next = dma_rd;
			wr_next = 1'b0;
		end else begin
			rd_next = cpu_rd && cpu_ext;
			wr_next = cpu_wr && cpu_ext;
		end
	end

	always_ff @(posedge gbclk) begin
		ext_adr <= (ext_owner == gb_bus_pkg::EXT_DMA) ? dma_adr_rd : cpu_adr;
	end

	always_ff @(posedge gbclk) begin
		if (!rst_n) begin
			ext_rd      <= 1'b0;
			ext_wr      <= 1'b0;
			ext_data_oe <= 1'b0;
			cs_rom      <= 1'b0;
			cs_xram     <= 1'b0;
			cs_wram     <= 1'b0;
		end else begin
			ext_rd <= rd_next;
			ext_wr <= reset_done && wr_next;
			// Data stays driven one cycle past the write strobe so the memory latches it
			ext_data_oe <= reset_done && (wr_next || ext_wr);
			cs_rom  <= reset_done && (cpu_sel.rom || dma_sel.rom);
			cs_xram <= reset_done && (cpu_sel.xram || dma_sel.xram);
			cs_wram <= cpu_sel.wram || dma_sel.wram;
		end
	end

endmodule

/* design/gb_mem_decode.sv */
`timescale 1ns/1ns
`include "gb_config.svh"

module gb_mem_decode (
	input  gb_bus_pkg::gb_adr_t adr,
	input  logic                enable,
	gb_mem_sel_if.decoder       sel
);

	logic in_rom;
	logic in_vram;
	logic in_xram;
	logic in_wram;
	logic in_oam;
	logic in_io;

	assign in_rom  = adr < `GB_VRAM_BASE;
	assign in_vram = (adr >= `GB_VRAM_BASE) && (adr < `GB_XRAM_BASE);
	assign in_xram = (adr >= `GB_XRAM_BASE) && (adr < `GB_WRAM_BASE);

	// Echo RAM at E000 mirrors work RAM, so it decodes the same way
	assign in_wram = (adr >= `GB_WRAM_BASE) && (adr < `GB_ECHO_END);
	assign in_oam  = (adr >= `GB_OAM_BASE) && (adr < `GB_OAM_END);

	// HRAM and IE live at the top of the I/O page as well
	assign in_io   = adr >= `GB_IO_BASE;

	always_comb begin
		sel.rom  = enable && in_rom;
		sel.vram = enable && in_vram;
		sel.xram = enable && in_xram;
		sel.wram = enable && in_wram;
		sel.oam  = enable && in_oam;
		sel.io   = enable && in_io;

		// Region boundaries out of order would select two regions at once
		assert ($onehot0({sel.rom, sel.xram, sel.wram, sel.vram, sel.oam, sel.io}))
			else $error("gb_mem_decode: overlapping regions for address %h", adr);
	end

endmodule

/* design/gb_mem_sel_if.sv */
`timescale 1ns/1ns

// Region selects of one bus master with at most one high at a time
interface gb_mem_sel_if;

	logic rom;
	logic xram;
	logic wram;
	logic vram;
	logic oam;
	logic io;

	modport decoder (
		output rom, xram, wram, vram, oam, io
	);

	modport ctrl (
		input rom, xram, wram, vram, oam, io
	);

endinterface

/* design/gb_reset_seq.sv */
`timescale 1ns/1ns
`include "gb_config.svh"

module gb_reset_seq (
	input  logic gbclk,
	input  logic rst_n,
	input  logic power_on,
	output logic reset_done,
	output logic reset_gb
);

	localparam int cnt_w = $clog2(`GB_RESET_TICKS + 1);
	localparam logic [cnt_w-1:0] last_tick = cnt_w'(`GB_RESET_TICKS);

	gb_bus_pkg::reset_state_e state;
	gb_bus_pkg::reset_state_e state_next;
	logic [cnt_w-1:0]         count;
	logic [cnt_w-1:0]         count_next;
	logic                     power_q;

	// Flipping the power switch either way restarts the whole count
	always_comb begin
		state_next = state;
		count_next = count;
		if (power_on != power_q) begin
			state_next = gb_bus_pkg::RST_COUNT;
			count_next = '0;
		end else if (state == gb_bus_pkg::RST_COUNT) begin
			if (count == last_tick)
				state_next = power_on ? gb_bus_pkg::RST_RUN : gb_bus_pkg::RST_OFF;
			else
				count_next = count + 1'b1;
		end
	end

	always_ff @(posedge gbclk) begin
		if (!rst_n) begin
			state      <= gb_bus_pkg::RST_COUNT;
			count      <= '0;
			power_q    <= power_on;
			reset_done <= 1'b0;
			reset_gb   <= 1'b1;
		end else begin
			state    <= state_next;
			count    <= count_next;
			power_q  <= power_on;
			reset_gb <= state_next != gb_bus_pkg::RST_RUN;
			// Stays set once the first count has finished
			if (state_next != gb_bus_pkg::RST_COUNT)
				reset_done <= 1'b1;
		end
	end

	// The console leaves reset only at the end of a full count
	assert property (@(posedge gbclk) disable iff (!rst_n)
		$fell(reset_gb) |-> $past(state) == gb_bus_pkg::RST_COUNT && $past(count) == last_tick)
		else $error("gb_reset_seq: console left reset before the count finished");

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the bus fabric testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_gb_bus_fabric \
	-f sim.f \
	-o tb_gb_bus_fabric

out=$(./obj_dir/tb_gb_bus_fabric) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
	exit 0
fi
exit 1

/* sim.f */
+incdir+design
design/gb_bus_pkg.sv
design/gb_mem_sel_if.sv
design/gb_mem_decode.sv
design/gb_access_ctrl.sv
design/gb_bus_mux.sv
design/gb_ext_port.sv
design/gb_reset_seq.sv
design/gb_bus_fabric.sv
tests/tb_gb_bus_fabric.sv

/* tests/gb_bus_golden.txt */
// test hold ctrl cpu_adr dma_adr ppu_adr wdata rdata flags cpu_din dma_din vram oam oam_din ext
// ctrl bits: power_on cpu_rd cpu_wr dma_active dma_rd dma_wr ppu_need_vram ppu_need_oam ppu_rd
// flags bits: vram_rd vram_wr oam_rd oam_wr ext_rd ext_wr ext_data_oe cs_rom cs_xram cs_wram reset_gb
// wdata is cpu_dout dma_dout, rdata is vram_dout oam_dout ext_data_in io_dout, all hex
01 0F 001 0000 0000 0000 C1D2 5A3CE799 400 E7 FF 0000 00 C1 0000
01 01 001 C000 0000 0000 C1D2 5A3CE799 200 E7 FF 0000 00 C1 C000
02 01 000 FEA0 0000 0000 C1D2 5A3CE799 400 FF FF 0000 00 C1 FEA0
02 14 000 FEA0 0000 0000 C1D2 5A3CE799 400 FF FF 0000 00 C1 FEA0
02 01 001 FEA0 0000 0000 C1D2 5A3CE799 400 FF FF 0000 00 C1 FEA0
02 0F 001 FEA0 0000 0000 C1D2 5A3CE799 400 FF FF 0000 00 C1 FEA0
02 01 001 FEA0 0000 0000 C1D2 5A3CE799 000 FF FF 0000 00 C1 FEA0
03 01 003 0150 0000 0000 C1D2 5A3CE799 090 E7 FF 0000 00 C1 0150
03 01 003 7FFF 0000 0000 C1D2 5A3CE799 090 E7 FF 0000 00 C1 7FFF
03 01 003 A123 0000 0000 C1D2 5A3C6B99 110 6B FF 0000 00 C1 A123
03 01 003 C234 0000 0000 C1D2 5A3CE799 210 E7 FF 0000 00 C1 C234
03 01 003 E345 0000 0000 C1D2 5A3CE799 210 E7 FF 0000 00 C1 E345
03 01 003 FDFF 0000 0000 C1D2 5A3CE799 210 E7 FF 0000 00 C1 FDFF
03 01 003 FEA0 0000 0000 C1D2 5A3CE799 000 FF FF 0000 00 C1 FEA0
03 01 003 FF44 0000 0000 C1D2 5A3CE742 000 42 FF 0000 00 C1 FF44
03 01 003 FFFF 0000 0000 C1D2 5A3CE799 000 99 FF 0000 00 C1 FFFF
04 01 15B 8123 8456 9ABC C1D2 5A3CE799 001 FF FF 1ABC 56 D2 8123
04 01 01B 8123 8456 9ABC C1D2 5A3CE799 001 FF 5A 0456 56 D2 8123
04 01 003 8123 8456 9ABC C1D2 5A3CE799 001 5A FF 0123 00 C1 8123
04 01 005 8123 8456 9ABC C1D2 5A3CE799 002 5A FF 0123 00 C1 8123
05 01 02B FE20 C012 0000 C1D2 5A3CE799 208 FF E7 0000 12 D2 C012
05 01 02B FE20 C013 0000 C1A7 5A3CE799 208 FF E7 0000 13 A7 C013
05 01 003 FE20 C013 0000 C1D2 5A3CE799 004 3C FF 0000 20 C1 FE20
06 01 01D C100 D200 0000 C1D2 5A3CE799 210 FF E7 0000 00 D2 D200
06 01 005 C100 D200 0000 C1D2 5A3CE799 260 E7 FF 0000 00 C1 C100
06 01 001 C100 D200 0000 C1D2 5A3CE799 240 E7 FF 0000 00 C1 C100
06 01 001 C100 D200 0000 C1D2 5A3CE799 200 E7 FF 0000 00 C1 C100

/* tests/tb_gb_bus_fabric.sv */
`timescale 1ns/1ns

module tb_gb_bus_fabric;

	// Each golden line holds the inputs and the outputs expected after its hold cycles
	typedef struct {
		int                       test;
		int                       hold;
		logic [8:0]               ctrl;
		gb_bus_pkg::gb_adr_t      cpu_adr;
		gb_bus_pkg::gb_adr_t      dma_adr;
		gb_bus_pkg::gb_adr_t      ppu_adr;
		logic [15:0]              wdata;
		logic [31:0]              rdata;
		logic [10:0]              flags;
		gb_bus_pkg::gb_data_t     cpu_din;
		gb_bus_pkg::gb_data_t     dma_din;
		gb_bus_pkg::gb_vram_adr_t vram_adr;
		gb_bus_pkg::gb_oam_adr_t  oam_adr;
		gb_bus_pkg::gb_data_t     oam_din;
		gb_bus_pkg::gb_adr_t      ext_adr;
	} vector_t;

	logic                     gbclk, rst_n, power_on;
	gb_bus_pkg::gb_adr_t      cpu_adr, dma_adr_rd, ppu_adr, ext_adr;
	gb_bus_pkg::gb_oam_adr_t  dma_adr_wr, oam_adr;
	gb_bus_pkg::gb_vram_adr_t vram_adr;
	gb_bus_pkg::gb_data_t     cpu_dout, cpu_din, dma_dout, dma_din, oam_din;
	gb_bus_pkg::gb_data_t     vram_dout, oam_dout, ext_data_in, io_dout;
	logic                     cpu_rd, cpu_wr, dma_active, dma_rd, dma_wr;
	logic                     ppu_need_vram, ppu_need_oam, ppu_rd;
	logic                     vram_rd, vram_wr, oam_rd, oam_wr;
	logic                     ext_rd, ext_wr, ext_data_oe, cs_rom, cs_xram, cs_wram, reset_gb;

	vector_t vectors[$];
	int      errors = 0;
	int      checks = 0;
	int      test_errors = 0;
	int      tests_run = 0;
	int      tests_failed = 0;
	int      cur_test = 0;
	int      total_cycles = 0;
	int      cycle_limit = 50;
	int      cycles = 0;

	gb_bus_fabric u_dut (.*);

	initial begin
		gbclk = 1'b0;
		forever #4 gbclk = ~gbclk;
	end

	always @(posedge gbclk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout after %0d cycles, the vectors did not finish", cycles);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	task automatic data_check(input string name, input gb_bus_pkg::gb_data_t got,
			input gb_bus_pkg::gb_data_t exp);
		checks++;
		if (got !== exp) begin
			$display("CHECK FAILED test %0d %s: got %h expected %h", cur_test, name, got, exp);
			test_errors++;
		end
	endtask

	task automatic adr_check(input string name, input gb_bus_pkg::gb_adr_t got,
			input gb_bus_pkg::gb_adr_t exp);
		checks++;
		if (got !== exp) begin
			$display("CHECK FAILED test %0d %s: got %h expected %h", cur_test, name, got, exp);
			test_errors++;
		end
	endtask

	task automatic vram_adr_check(input string name, input gb_bus_pkg::gb_vram_adr_t got,
			input gb_bus_pkg::gb_vram_adr_t exp);
		checks++;
		if (got !== exp) begin
			$display("CHECK FAILED test %0d %s: got %h expected %h", cur_test, name, got, exp);
			test_errors++;
		end
	endtask

	task automatic oam_adr_check(input string name, input gb_bus_pkg::gb_oam_adr_t got,
			input gb_bus_pkg::gb_oam_adr_t exp);
		checks++;
		if (got !== exp) begin
			$display("CHECK FAILED test %0d %s: got %h expected %h", cur_test, name, got, exp);
			test_errors++;
		end
	endtask

	task automatic bit_check(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			$display("CHECK FAILED test %0d %s: got %h expected %h", cur_test, name, got, exp);
			test_errors++;
		end
	endtask

	task automatic init_inputs();
		rst_n         = 1'b0;
		power_on      = 1'b1;
		cpu_adr       = '0;
		cpu_rd        = 1'b0;
		cpu_wr        = 1'b0;
		cpu_dout      = '0;
		dma_active    = 1'b0;
		dma_adr_rd    = '0;
		dma_adr_wr    = '0;
		dma_rd        = 1'b0;
		dma_wr        = 1'b0;
		dma_dout      = '0;
		ppu_need_vram = 1'b0;
		ppu_need_oam  = 1'b0;
		ppu_adr       = '0;
		ppu_rd        = 1'b0;
		vram_dout     = '0;
		oam_dout      = '0;
		ext_data_in   = '0;
		io_dout       = '0;
	endtask

	task automatic load_vectors();
		int          fd;
		int          n;
		string       line;
		logic [31:0] f [15];
		vector_t     v;
		fd = $fopen("tests/gb_bus_golden.txt", "r");
		if (fd == 0) begin
			$display("Could not open the golden vector file tests/gb_bus_golden.txt");
			errors++;
			return;
		end
		while ($fgets(line, fd) != 0) begin
			n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
				f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
			if (n == 15) begin
				v.test     = f[0];
				v.hold     = f[1];
				v.ctrl     = f[2][8:0];
				v.cpu_adr  = f[3][15:0];
				v.dma_adr  = f[4][15:0];
				v.ppu_adr  = f[5][15:0];
				v.wdata    = f[6][15:0];
				v.rdata    = f[7];
				v.flags    = f[8][10:0];
				v.cpu_din  = f[9][7:0];
				v.dma_din  = f[10][7:0];
				v.vram_adr = f[11][12:0];
				v.oam_adr  = f[12][7:0];
				v.oam_din  = f[13][7:0];
				v.ext_adr  = f[14][15:0];
				vectors.push_back(v);
				total_cycles += v.hold;
			end else if (n > 0) begin
				$display("Malformed line in the golden vector file: %s", line);
				errors++;
			end
		end
		$fclose(fd);
		if (vectors.size() == 0) begin
			$display("The golden vector file holds no vectors");
			errors++;
		end
	endtask

	task automatic apply_vector(input vector_t v);
		power_on      = v.ctrl[0];
		cpu_rd        = v.ctrl[1];
		cpu_wr        = v.ctrl[2];
		dma_active    = v.ctrl[3];
		dma_rd        = v.ctrl[4];
		dma_wr        = v.ctrl[5];
		ppu_need_vram = v.ctrl[6];
		ppu_need_oam  = v.ctrl[7];
		ppu_rd        = v.ctrl[8];
		cpu_adr       = v.cpu_adr;
		// OAM DMA writes the low byte of the address it reads from
		dma_adr_rd    = v.dma_adr;
		dma_adr_wr    = v.dma_adr[7:0];
		ppu_adr       = v.ppu_adr;
		cpu_dout      = v.wdata[15:8];
		dma_dout      = v.wdata[7:0];
		vram_dout     = v.rdata[31:24];
		oam_dout      = v.rdata[23:16];
		ext_data_in   = v.rdata[15:8];
		io_dout       = v.rdata[7:0];
	endtask

	task automatic compare_outputs(input vector_t v);
		data_check("cpu_din", cpu_din, v.cpu_din);
		data_check("dma_din", dma_din, v.dma_din);
		data_check("oam_din", oam_din, v.oam_din);
		vram_adr_check("vram_adr", vram_adr, v.vram_adr);
		oam_adr_check("oam_adr", oam_adr, v.oam_adr);
		bit_check("vram_rd", vram_rd, v.flags[0]);
		bit_check("vram_wr", vram_wr, v.flags[1]);
		bit_check("oam_rd", oam_rd, v.flags[2]);
		bit_check("oam_wr", oam_wr, v.flags[3]);
		// Registered outputs were updated by the clock edge before this sample
		adr_check("ext_adr", ext_adr, v.ext_adr);
		bit_check("ext_rd", ext_rd, v.flags[4]);
		bit_check("ext_wr", ext_wr, v.flags[5]);
		bit_check("ext_data_oe", ext_data_oe, v.flags[6]);
		bit_check("cs_rom", cs_rom, v.flags[7]);
		bit_check("cs_xram", cs_xram, v.flags[8]);
		bit_check("cs_wram", cs_wram, v.flags[9]);
		bit_check("reset_gb", reset_gb, v.flags[10]);
	endtask

	task automatic close_test();
		if (cur_test != 0) begin
			tests_run++;
			if (test_errors == 0) begin
				$display("test %0d passed", cur_test);
			end else begin
				$display("test %0d failed with %0d errors", cur_test, test_errors);
				tests_failed++;
			end
			errors += test_errors;
			test_errors = 0;
		end
	endtask

	initial begin
		init_inputs();
		load_vectors();
		cycle_limit = 2 * total_cycles + 50;
		repeat (3) @(posedge gbclk);
		@(negedge gbclk);
		rst_n = 1'b1;
		foreach (vectors[i]) begin
			if (vectors[i].test != cur_test) begin
				close_test();
				cur_test = vectors[i].test;
			end
			apply_vector(vectors[i]);
			repeat (vectors[i].hold) @(negedge gbclk);
			compare_outputs(vectors[i]);
		end
		close_test();
		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule
